//--- rtl/feed_pkg.sv
package feed_pkg;

   ////////////////////////////////////////////////////////////
   // Word and sample format
   ////////////////////////////////////////////////////////////

   // Width of one incoming data word
   localparam int WORD_WIDTH = 16;

   // Width of one output sample
   localparam int SAMPLE_WIDTH = 3;

   // Whole samples in a word, one spare bit is left over
   localparam int SAMPLES_PER_WORD = 5;

   // Three words hold 48 bits, which is exactly 16 samples,
   // so the spare-bit count repeats every three words
   localparam int WORDS_PER_GROUP = 3;

endpackage

//--- rtl/feed_regs_pkg.sv
package feed_regs_pkg;

   ////////////////////////////////////////////////////////////
   // APB bus widths
   ////////////////////////////////////////////////////////////

   localparam int APB_ADDR_WIDTH = 4;
   localparam int APB_DATA_WIDTH = 32;

   // Register word addresses
   typedef enum logic [APB_ADDR_WIDTH-1:0] {
      REG_CTRL         = 4'h0,
      REG_STATUS       = 4'h4,
      REG_WORD_COUNT   = 4'h8,
      REG_SAMPLE_COUNT = 4'hc
   } reg_addr_e;

   // Control register fields
   localparam int CTRL_ENABLE_BIT = 0;
   // Self-clearing, reads back as zero
   localparam int CTRL_CLEAR_BIT  = 1;

endpackage

//--- rtl/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                            clk_sample,
   input  logic                            reset,
   // Write side
   input  logic                            word_valid,
   input  logic [feed_pkg::WORD_WIDTH-1:0] word_data,
   output logic                            word_ready,
   // Read side, first word falls through
   output logic                            fifo_empty,
   output logic [feed_pkg::WORD_WIDTH-1:0] fifo_data,
   input  logic                            read_next,
   // Fill level
   output logic [$clog2(FIFO_DEPTH):0]     words_available
);

   localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
   localparam int PTR_WIDTH  = ADDR_WIDTH + 1;

   logic [feed_pkg::WORD_WIDTH-1:0] mem [FIFO_DEPTH];
   logic [PTR_WIDTH-1:0]            wr_ptr;
   logic [PTR_WIDTH-1:0]            rd_ptr;
   logic                            full;
   logic                            push;

   // Extra pointer bit tells a full buffer from an empty one
   assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                 (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
   assign fifo_empty = (wr_ptr == rd_ptr);

   assign word_ready = !full;
   assign push       = word_valid && word_ready;

   // Oldest word is always visible at the read pointer
   assign fifo_data = mem[rd_ptr[ADDR_WIDTH-1:0]];

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_sample) begin
      if (push) begin
         mem[wr_ptr[ADDR_WIDTH-1:0]] <= word_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Pointers and fill level
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_sample or posedge reset) begin
      if (reset) begin
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         words_available <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + PTR_WIDTH'(1);
         end
         // Caller only pops when not empty
         if (read_next) begin
            rd_ptr <= rd_ptr + PTR_WIDTH'(1);
         end
         case ({push, read_next})
            2'b10:   words_available <= words_available + PTR_WIDTH'(1);
            2'b01:   words_available <= words_available - PTR_WIDTH'(1);
            default: words_available <= words_available;
         endcase
      end
   end

endmodule

//--- rtl/feed_apb_regs.sv
`timescale 1ns/1ps

module feed_apb_regs #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                                      clk_sample,
   input  logic                                      reset,
   // APB slave
   input  logic [feed_regs_pkg::APB_ADDR_WIDTH-1:0]  paddr,
   input  logic                                      psel,
   input  logic                                      penable,
   input  logic                                      pwrite,
   input  logic [feed_regs_pkg::APB_DATA_WIDTH-1:0]  pwdata,
   output logic [feed_regs_pkg::APB_DATA_WIDTH-1:0]  prdata,
   output logic                                      pready,
   output logic                                      pslverr,
   // Datapath status and events
   input  logic [$clog2(FIFO_DEPTH):0]               words_available,
   input  logic                                      read_next,
   input  logic                                      sample_valid,
   // Feed control
   output logic                                      enable
);

   localparam int DATA_WIDTH  = feed_regs_pkg::APB_DATA_WIDTH;
   localparam int LEVEL_WIDTH = $clog2(FIFO_DEPTH) + 1;

   feed_regs_pkg::reg_addr_e reg_addr;

   logic                  access;
   logic                  addr_mapped;
   logic                  addr_read_only;
   logic                  ctrl_write;
   logic                  clear_counts;
   logic [DATA_WIDTH-1:0] read_data;
   logic [DATA_WIDTH-1:0] word_count;
   logic [DATA_WIDTH-1:0] sample_count;

   assign reg_addr = feed_regs_pkg::reg_addr_e'(paddr);

   // No wait states
   assign access = psel && penable;
   assign pready = 1'b1;

   ////////////////////////////////////////////////////////////
   // Address decode and read mux
   ////////////////////////////////////////////////////////////

   always_comb begin
      addr_mapped    = 1'b1;
      addr_read_only = 1'b1;
      read_data      = '0;
      case (reg_addr)
         feed_regs_pkg::REG_CTRL: begin
            addr_read_only = 1'b0;
            // Clear bit always reads as zero
            read_data[feed_regs_pkg::CTRL_ENABLE_BIT] = enable;
         end
         feed_regs_pkg::REG_STATUS: begin
            read_data[LEVEL_WIDTH-1:0] = words_available;
         end
         feed_regs_pkg::REG_WORD_COUNT: begin
            read_data = word_count;
         end
         feed_regs_pkg::REG_SAMPLE_COUNT: begin
            read_data = sample_count;
         end
         default: begin
            addr_mapped = 1'b0;
         end
      endcase
   end

   assign prdata  = read_data;
   assign pslverr = access && (!addr_mapped || (pwrite && addr_read_only));

   assign ctrl_write   = access && pwrite && (reg_addr == feed_regs_pkg::REG_CTRL);
   assign clear_counts = ctrl_write && pwdata[feed_regs_pkg::CTRL_CLEAR_BIT];

   ////////////////////////////////////////////////////////////
   // Control register and counters
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_sample or posedge reset) begin
      if (reset) begin
         enable       <= 1'b0;
         word_count   <= '0;
         sample_count <= '0;
      end else begin
         if (ctrl_write) begin
            enable <= pwdata[feed_regs_pkg::CTRL_ENABLE_BIT];
         end
         // Clear takes priority over a count on the same edge
         if (clear_counts) begin
            word_count   <= '0;
            sample_count <= '0;
         end else begin
            if (read_next) begin
               word_count <= word_count + DATA_WIDTH'(1);
            end
            if (sample_valid) begin
               sample_count <= sample_count + DATA_WIDTH'(1);
            end
         end
      end
   end

endmodule

//--- rtl/sample_unpacker.sv
`timescale 1ns/1ps

module sample_unpacker (
   input  logic                              clk_sample,
   input  logic                              reset,
   input  logic                              enable,
   // FIFO read side
   input  logic                              fifo_empty,
   input  logic [feed_pkg::WORD_WIDTH-1:0]   fifo_data,
   output logic                              read_next,
   // Sample stream
   output logic                              sample_valid,
   output logic [feed_pkg::SAMPLE_WIDTH-1:0] sample_data
);

   // One word plus up to two held spare bits
   localparam int BUF_WIDTH   = feed_pkg::WORD_WIDTH + feed_pkg::WORDS_PER_GROUP - 1;
   localparam int COUNT_WIDTH = $clog2(feed_pkg::SAMPLES_PER_WORD + 2);
   localparam int SPARE_WIDTH = $clog2(feed_pkg::WORDS_PER_GROUP);
   localparam int SPARE_MAX   = feed_pkg::WORDS_PER_GROUP - 1;

   logic [BUF_WIDTH-1:0]   sample_buffer;
   logic [BUF_WIDTH-1:0]   shifted_buffer;
   logic [BUF_WIDTH-1:0]   spare_mask;
   logic [BUF_WIDTH-1:0]   next_buffer;
   logic [COUNT_WIDTH-1:0] sample_count;
   logic [COUNT_WIDTH-1:0] next_count;
   logic [SPARE_WIDTH-1:0] spare_count;
   logic [SPARE_WIDTH-1:0] next_spare;
   logic                   samples_present;

   assign samples_present = (sample_count != '0);

   // Fetch once the buffer is about to run dry, so output stays continuous
   assign read_next = !fifo_empty && enable && (sample_count < COUNT_WIDTH'(2));

   // Buffer after this cycle's sample has been taken off the bottom
   assign shifted_buffer = samples_present ? (sample_buffer >> feed_pkg::SAMPLE_WIDTH)
                                           : sample_buffer;

   // Leftover spare bits sit at the bottom once the samples are gone
   assign spare_mask = (BUF_WIDTH'(1) << spare_count) - BUF_WIDTH'(1);

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////

   always_comb begin
      next_buffer = shifted_buffer;
      next_count  = samples_present ? (sample_count - COUNT_WIDTH'(1)) : sample_count;
      next_spare  = spare_count;
      if (read_next) begin
         // New word goes right above the held spare bits
         next_buffer = (BUF_WIDTH'(fifo_data) << spare_count) | (shifted_buffer & spare_mask);
         if (spare_count == SPARE_WIDTH'(SPARE_MAX)) begin
            // Two spares plus this word's bit make a sixth sample
            next_count = COUNT_WIDTH'(feed_pkg::SAMPLES_PER_WORD + 1);
            next_spare = '0;
         end else begin
            next_count = COUNT_WIDTH'(feed_pkg::SAMPLES_PER_WORD);
            next_spare = spare_count + SPARE_WIDTH'(1);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_sample or posedge reset) begin
      if (reset) begin
         sample_count <= '0;
         spare_count  <= '0;
         sample_valid <= 1'b0;
      end else begin
         sample_count <= next_count;
         spare_count  <= next_spare;
         sample_valid <= samples_present;
      end
   end

   // Payload, qualified by sample_valid and the counts above
   always_ff @(posedge clk_sample) begin
      sample_buffer <= next_buffer;
      sample_data   <= sample_buffer[feed_pkg::SAMPLE_WIDTH-1:0];
   end

endmodule

//--- rtl/rt_data_feed.sv
`timescale 1ns/1ps

module rt_data_feed #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                                     clk_sample,
   input  logic                                     reset,
   // Word input
   input  logic                                     word_valid,
   input  logic [feed_pkg::WORD_WIDTH-1:0]          word_data,
   output logic                                     word_ready,
   // Sample output
   output logic                                     sample_valid,
   output logic [feed_pkg::SAMPLE_WIDTH-1:0]        sample_data,
   // APB register access
   input  logic [feed_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
   input  logic                                     psel,
   input  logic                                     penable,
   input  logic                                     pwrite,
   input  logic [feed_regs_pkg::APB_DATA_WIDTH-1:0] pwdata,
   output logic [feed_regs_pkg::APB_DATA_WIDTH-1:0] prdata,
   output logic                                     pready,
   output logic                                     pslverr
);

   logic                            fifo_empty;
   logic [feed_pkg::WORD_WIDTH-1:0] fifo_data;
   logic                            read_next;
   logic [$clog2(FIFO_DEPTH):0]     words_available;
   logic                            enable;

   word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_word_fifo (
      .clk_sample(clk_sample), .reset(reset),
      .word_valid(word_valid), .word_data(word_data), .word_ready(word_ready),
      .fifo_empty(fifo_empty), .fifo_data(fifo_data), .read_next(read_next),
      .words_available(words_available)
   );

   feed_apb_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_feed_apb_regs (
      .clk_sample(clk_sample), .reset(reset),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .words_available(words_available), .read_next(read_next),
      .sample_valid(sample_valid), .enable(enable)
   );

   // Feeds on FIFO data once enabled by software
   sample_unpacker u_sample_unpacker (
      .clk_sample(clk_sample), .reset(reset), .enable(enable),
      .fifo_empty(fifo_empty), .fifo_data(fifo_data), .read_next(read_next),
      .sample_valid(sample_valid), .sample_data(sample_data)
   );

endmodule

//--- testbench/rt_data_feed_props.sv
`timescale 1ns/1ps

module rt_data_feed_props #(
   parameter int FIFO_DEPTH = 16
) (
   input logic                        clk_sample,
   input logic                        reset,
   input logic                        word_valid,
   input logic                        word_ready,
   input logic [$clog2(FIFO_DEPTH):0] words_available,
   input logic                        read_next,
   input logic                        fifo_empty,
   input logic                        pready,
   input logic                        sample_valid
);

   // Unpacker never pops an empty FIFO
   no_pop_when_empty: assert property (@(posedge clk_sample) disable iff (reset)
      !(read_next && fifo_empty))
      else $error("read_next high while fifo_empty high");

   pready_high: assert property (@(posedge clk_sample) disable iff (reset) pready)
      else $error("pready dropped low");

   quiet_in_reset: assert property (@(posedge clk_sample) reset |-> !sample_valid)
      else $error("sample_valid high during reset");

   // A blocked word leaves the fill level unchanged or lower
   no_push_when_full: assert property (@(posedge clk_sample) disable iff (reset)
      (word_valid && !word_ready) |=> (words_available <= $past(words_available)))
      else $error("Word accepted while word_ready was low");

endmodule

bind rt_data_feed rt_data_feed_props #(.FIFO_DEPTH(FIFO_DEPTH)) u_props (
   .clk_sample(clk_sample), .reset(reset),
   .word_valid(word_valid), .word_ready(word_ready),
   .words_available(words_available), .read_next(read_next),
   .fifo_empty(fifo_empty), .pready(pready), .sample_valid(sample_valid)
);

//--- testbench/tb_rt_data_feed.sv
`timescale 1ns/1ps

module tb_rt_data_feed;

   localparam int FIFO_DEPTH = 16;
   localparam int TIMEOUT    = 2000;
   localparam int ADDR_W     = feed_regs_pkg::APB_ADDR_WIDTH;
   localparam int DATA_W     = feed_regs_pkg::APB_DATA_WIDTH;

   typedef logic [feed_pkg::WORD_WIDTH-1:0]   word_t;
   typedef logic [feed_pkg::SAMPLE_WIDTH-1:0] sample_t;
   typedef word_t   word_q_t[$];
   typedef sample_t sample_q_t[$];

   logic              clk_sample;
   logic              reset;
   logic              word_valid;
   word_t             word_data;
   logic              word_ready;
   logic              sample_valid;
   sample_t           sample_data;
   logic [ADDR_W-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;

   word_q_t pushed_words;
   int      samples_seen = 0;

   rt_data_feed #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
      .clk_sample(clk_sample), .reset(reset),
      .word_valid(word_valid), .word_data(word_data), .word_ready(word_ready),
      .sample_valid(sample_valid), .sample_data(sample_data),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   initial begin : clock_gen
      clk_sample = 1'b0;
      forever begin
         #50 clk_sample = ~clk_sample;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model and check helpers
   ////////////////////////////////////////////////////////////

   // Words joined LSB first, cut into whole 3-bit groups
   function automatic sample_q_t compute_samples(word_q_t words);
      sample_q_t   samples;
      logic [31:0] bits;
      int          held;
      bits = '0;
      held = 0;
      foreach (words[i]) begin
         bits = bits | (32'(words[i]) << held);
         held = held + feed_pkg::WORD_WIDTH;
         while (held >= feed_pkg::SAMPLE_WIDTH) begin
            samples.push_back(bits[feed_pkg::SAMPLE_WIDTH-1:0]);
            bits = bits >> feed_pkg::SAMPLE_WIDTH;
            held = held - feed_pkg::SAMPLE_WIDTH;
         end
      end
      return samples;
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else stop_with_failure(
         $sformatf("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got));
   endtask

   // Inputs change just after the rising edge
   task automatic next_cycle();
      @(posedge clk_sample);
      #1;
   endtask

   task automatic idle_cycles(input int count);
      repeat (count) next_cycle();
   endtask

   // Setup phase, then access phase until pready
   task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err);
      int waited;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      next_cycle();
      penable = 1'b1;
      waited  = 0;
      @(negedge clk_sample);
      while (!pready) begin
         waited++;
         assert (waited <= TIMEOUT) else stop_with_failure("APB slave never raised pready");
         @(negedge clk_sample);
      end
      rdata = prdata;
      err   = pslverr;
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] rdata;
      logic              err;
      apb_transfer(1'b1, addr, data, rdata, err);
      check_value("pslverr", err, 0);
   endtask

   task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      logic err;
      apb_transfer(1'b0, addr, '0, data, err);
      check_value("pslverr", err, 0);
   endtask

   // word_ready is stable at the falling edge before the accepting edge
   task automatic try_push(input word_t data, output bit accepted);
      word_valid = 1'b1;
      word_data  = data;
      @(negedge clk_sample);
      accepted = word_ready;
      if (accepted) begin
         pushed_words.push_back(data);
      end
      next_cycle();
      word_valid = 1'b0;
   endtask

   task automatic push_word(input word_t data);
      bit accepted;
      int waited;
      waited = 0;
      try_push(data, accepted);
      while (!accepted) begin
         waited++;
         assert (waited <= TIMEOUT) else stop_with_failure("Word input stayed blocked");
         try_push(data, accepted);
      end
   endtask

   // Halt counts as seen once the output stays quiet for a few cycles
   task automatic wait_stream_idle();
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while (quiet < 8) begin
         next_cycle();
         quiet = sample_valid ? 0 : quiet + 1;
         waited++;
         assert (waited <= TIMEOUT) else stop_with_failure("Sample stream did not stop on halt");
      end
   endtask

   task automatic wait_stream_drained();
      sample_q_t all_samples;
      int        waited;
      all_samples = compute_samples(pushed_words);
      waited      = 0;
      while (samples_seen < all_samples.size()) begin
         next_cycle();
         waited++;
         assert (waited <= TIMEOUT) else stop_with_failure("Sample stream never drained");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sample monitor
   ////////////////////////////////////////////////////////////

   initial begin : compare_samples
      sample_q_t expected;
      forever begin
         @(negedge clk_sample);
         if (!reset && sample_valid) begin
            if (samples_seen >= expected.size()) begin
               expected = compute_samples(pushed_words);
            end
            assert (samples_seen < expected.size())
               else stop_with_failure("DUT produced more samples than the pushed words hold");
            assert (sample_data === expected[samples_seen]) else stop_with_failure(
               $sformatf("[FAIL] t=%0t sample_data expected %0d got %0d",
                         $time, expected[samples_seen], sample_data));
            samples_seen++;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin : run_test
      logic [DATA_W-1:0] rdata;
      logic              err;
      bit                accepted;
      int                accepted_count;
      void'($urandom(32'hd471));
      reset      = 1'b1;
      word_valid = 1'b0;
      word_data  = '0;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      repeat (5) @(posedge clk_sample);
      #1;
      reset = 1'b0;
      next_cycle();

      // Feed starts halted, so the FIFO fills up
      accepted_count = 0;
      accepted       = 1'b1;
      while (accepted && accepted_count <= FIFO_DEPTH) begin
         try_push(word_t'($urandom), accepted);
         if (accepted) begin
            accepted_count++;
         end
      end
      check_value("accepted words", accepted_count, FIFO_DEPTH);
      reg_read(feed_regs_pkg::REG_STATUS, rdata);
      check_value("REG_STATUS", rdata, FIFO_DEPTH);

      reg_write(feed_regs_pkg::REG_CTRL, 32'h1);
      repeat (20) begin
         idle_cycles($urandom_range(3));
         push_word(word_t'($urandom));
      end

      // Halt while words are still queued
      reg_write(feed_regs_pkg::REG_CTRL, 32'h0);
      wait_stream_idle();
      reg_read(feed_regs_pkg::REG_STATUS, rdata);
      assert (rdata != 0) else stop_with_failure("FIFO was already empty when the feed halted");
      reg_write(feed_regs_pkg::REG_CTRL, 32'h1);

      // Long gaps let the FIFO run dry with spare bits held
      repeat (30) begin
         idle_cycles($urandom_range(12));
         push_word(word_t'($urandom));
      end
      wait_stream_drained();

      reg_read(feed_regs_pkg::REG_WORD_COUNT, rdata);
      check_value("REG_WORD_COUNT", rdata, pushed_words.size());
      reg_read(feed_regs_pkg::REG_SAMPLE_COUNT, rdata);
      check_value("REG_SAMPLE_COUNT", rdata, compute_samples(pushed_words).size());
      reg_write(feed_regs_pkg::REG_CTRL, 32'h2);
      reg_read(feed_regs_pkg::REG_WORD_COUNT, rdata);
      check_value("REG_WORD_COUNT", rdata, 0);
      reg_read(feed_regs_pkg::REG_SAMPLE_COUNT, rdata);
      check_value("REG_SAMPLE_COUNT", rdata, 0);

      apb_transfer(1'b0, 4'h2, '0, rdata, err);
      check_value("pslverr", err, 1);
      apb_transfer(1'b1, feed_regs_pkg::REG_STATUS, 32'h5, rdata, err);
      check_value("pslverr", err, 1);
      apb_transfer(1'b0, feed_regs_pkg::REG_CTRL, '0, rdata, err);
      check_value("pslverr", err, 0);
      check_value("prdata", rdata, 0);

      $display("Test OK");
      $finish;
   end

endmodule

//--- compile.f
rtl/feed_pkg.sv
rtl/feed_regs_pkg.sv
rtl/word_fifo.sv
rtl/feed_apb_regs.sv
rtl/sample_unpacker.sv
rtl/rt_data_feed.sv
testbench/rt_data_feed_props.sv
testbench/tb_rt_data_feed.sv

//--- Bender.yml
package:
  name: rt_data_feed

sources:
  - files:
      - rtl/feed_pkg.sv
      - rtl/feed_regs_pkg.sv
      - rtl/word_fifo.sv
      - rtl/feed_apb_regs.sv
      - rtl/sample_unpacker.sv
      - rtl/rt_data_feed.sv
  - target: test
    files:
      - testbench/rt_data_feed_props.sv
      - testbench/tb_rt_data_feed.sv
